//--- project.f
source/host_chan_pkg.sv
source/mmio_split.sv
source/mmio64_map.sv
source/mmio512_map.sv
source/afu_csr.sv
source/host_afu_top.sv
verification/host_afu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the host channel front testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
    -f project.f \
    --top-module host_afu_tb \
    --Mdir obj_dir \
    -o host_afu_sim

./obj_dir/host_afu_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

//--- verification/host_afu_tb.sv
// Random-stimulus testbench for the host channel front with reference model, checks and summary
`default_nettype none

module host_afu_tb import host_chan_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_WORDS    = 2000;
    localparam int READ_LATENCY = 4;
    localparam int RESET_LIMIT  = 20;
    localparam int DRAIN_LIMIT  = 20;
    localparam int QUIET_CYCLES = 8;

    // Expected read response and the cycle in which it must show up on tx
    typedef struct packed {
        logic [31:0]       due;
        logic [TID_W-1:0]  tid;
        logic [WORD_W-1:0] data;
    } exp_rsp_t;

    logic     clk = 1'b0;
    logic     rst = 1'b1;
    rx_word_t rx;
    tx_word_t tx;

    // ====================
    // Reference model
    // ====================

    logic [SCRATCH_WORDS-1:0][WORD_W-1:0] m_scratch;
    line_u                                m_line;
    logic [WORD_W-1:0]                    m_count;
    exp_rsp_t                             exp_q[$];

    logic [31:0] rng;
    int          errors;
    int          checks;
    int          timeouts;
    int          cycle;

    host_afu_top UUT (
        .clk (clk),
        .rst (rst),
        .rx  (rx),
        .tx  (tx)
    );

    always #4 clk = ~clk;

    // Reset is released on the falling edge after four rising edges
    initial begin
        repeat (4) @(negedge clk);
        rst <= 1'b0;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_random(output logic [31:0] r);
        rng = xorshift(rng);
        r = rng;
    endtask

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0d ns: %s, got %h, expected %h", $time, msg, got, exp);
        end
    endtask

    // Host view of the register map, low three address bits select no byte here
    function automatic logic [WORD_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
        logic [ADDR_W-1:0] a;
        a = {addr[ADDR_W-1:3], 3'b000};
        if (a == CSR_ID_ADDR)
            return AFU_ID;
        if (a >= CSR_SCRATCH_BASE && a < CSR_SCRATCH_BASE + 16'h0020)
            return m_scratch[int'((a - CSR_SCRATCH_BASE) >> 3)];
        if (a == CSR_WR_COUNT_ADDR)
            return m_count;
        if (a >= LINE_BASE && a < LINE_BASE + 16'h0040)
            return m_line.words[int'((a - LINE_BASE) >> 3)];
        return '0;
    endfunction

    // Only scratch and line words take 8-byte writes, each one counts
    task automatic model_write8(input logic [ADDR_W-1:0] addr, input logic [WORD_W-1:0] data);
        logic [ADDR_W-1:0] a;
        a = {addr[ADDR_W-1:3], 3'b000};
        if (a >= CSR_SCRATCH_BASE && a < CSR_SCRATCH_BASE + 16'h0020) begin
            m_scratch[int'((a - CSR_SCRATCH_BASE) >> 3)] = data;
            m_count++;
        end else if (a >= LINE_BASE && a < LINE_BASE + 16'h0040) begin
            m_line.words[int'((a - LINE_BASE) >> 3)] = data;
            m_count++;
        end
    endtask

    // Updates happen in issue order so a read sees every earlier write
    task automatic apply_to_model(input rx_word_t w);
        exp_rsp_t e;
        if (w.kind == KIND_MMIO_RD && w.len == LEN_8B) begin
            e.due  = 32'(cycle + READ_LATENCY);
            e.tid  = w.tid;
            e.data = model_read(w.addr);
            exp_q.push_back(e);
        end else if (w.kind == KIND_MMIO_WR && w.len == LEN_8B) begin
            model_write8(w.addr, w.data.words[0]);
        end else if (w.kind == KIND_MMIO_WR && w.addr == LINE_BASE) begin
            m_line = w.data;
            m_count++;
        end
    endtask

    // ====================
    // Stimulus
    // ====================

    task automatic pick_address(output logic [ADDR_W-1:0] addr);
        logic [31:0] r;
        draw_random(r);
        case (r[2:0])
            3'd0:       addr = CSR_ID_ADDR;
            3'd1, 3'd2: addr = CSR_SCRATCH_BASE + ADDR_W'({r[9:8], 3'b000});
            3'd3:       addr = CSR_WR_COUNT_ADDR;
            3'd4, 3'd5: addr = LINE_BASE + ADDR_W'({r[10:8], 3'b000});
            3'd6: begin
                // Holes just around the mapped regions
                case (r[9:8])
                    2'd0:    addr = 16'h0030;
                    2'd1:    addr = 16'h00f8;
                    2'd2:    addr = 16'h0140;
                    default: addr = 16'h0800;
                endcase
            end
            default:    addr = {r[23:11], 3'b000};
        endcase
    endtask

    task automatic make_word(output rx_word_t w);
        logic [31:0]       r;
        logic [ADDR_W-1:0] a;
        int                i;
        w = '0;
        for (i = 0; i < LINE_W / 32; i++) begin
            draw_random(r);
            w.data.line[i*32 +: 32] = r;
        end
        draw_random(r);
        w.tid = r[TID_W-1:0];
        // Mostly MMIO traffic with some idle cycles and host responses mixed in
        if (r[15:12] < 4'd2)
            w.kind = KIND_NONE;
        else if (r[15:12] < 4'd4)
            w.kind = KIND_HOST_RSP;
        else if (r[15:12] < 4'd10)
            w.kind = KIND_MMIO_RD;
        else
            w.kind = KIND_MMIO_WR;
        if (r[22:20] < 3'd2)
            w.len = LEN_64B;
        else
            w.len = LEN_8B;
        pick_address(a);
        // Half the 64-byte requests go to the line base
        if (w.len == LEN_64B && r[24])
            a = LINE_BASE;
        w.addr = a;
    endtask

    // tx changed on the last rising edge and is stable at the falling edge
    task automatic check_tx();
        if (exp_q.size() > 0 && exp_q[0].due == 32'(cycle)) begin
            check(64'(tx.valid), 64'd1, "read response missing");
            check(64'(tx.tid), 64'(exp_q[0].tid), "read response tag");
            check(tx.data, exp_q[0].data, "read response data");
            void'(exp_q.pop_front());
        end else begin
            check(64'(tx.valid), 64'd0, "tx valid without a pending read");
        end
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        rx_word_t w;
        int       n;
        int       wait_cnt;
        rx        = '0;
        rng       = 32'd78842;
        errors    = 0;
        checks    = 0;
        timeouts  = 0;
        cycle     = 0;
        m_scratch = '0;
        m_line    = '0;
        m_count   = '0;
        wait_cnt  = 0;
        while (rst && wait_cnt < RESET_LIMIT) begin
            @(negedge clk);
            wait_cnt++;
        end
        if (rst) begin
            timeouts++;
            $display("Timeout: reset was never released");
        end else begin
            for (n = 0; n < NUM_WORDS; n++) begin
                @(negedge clk);
                check_tx();
                make_word(w);
                rx = w;
                apply_to_model(w);
                cycle++;
            end
            // Idle until every queued read has come back
            wait_cnt = 0;
            while (exp_q.size() > 0 && wait_cnt < DRAIN_LIMIT) begin
                @(negedge clk);
                check_tx();
                rx = '0;
                cycle++;
                wait_cnt++;
            end
            if (exp_q.size() > 0) begin
                timeouts++;
                $display("Timeout: %0d read responses never arrived", exp_q.size());
            end
            for (n = 0; n < QUIET_CYCLES; n++) begin
                @(negedge clk);
                check_tx();
                rx = '0;
                cycle++;
            end
        end
        $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/host_afu_top.sv
// Top level of the host channel front joining splitter, both mappers and CSR bank
`default_nettype none

module host_afu_top import host_chan_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire rx_word_t rx,
    output tx_word_t      tx
);

    // ====================
    // Internal channels
    // ====================

    mmio_req_t mmio_req;
    reg_req_t  reg_req;
    reg_rsp_t  reg_rsp;
    reg_rsp_t  mmio_rsp;
    line_wr_t  line_wr;

    // Splitter keeps MMIO traffic and owns the transmit register
    mmio_split u_split (
        .clk      (clk),
        .rst      (rst),
        .rx       (rx),
        .mmio_req (mmio_req),
        .mmio_rsp (mmio_rsp),
        .tx       (tx)
    );

    // 8-byte reads and writes
    mmio64_map u_mmio64 (
        .clk      (clk),
        .rst      (rst),
        .mmio_req (mmio_req),
        .reg_req  (reg_req),
        .reg_rsp  (reg_rsp),
        .mmio_rsp (mmio_rsp)
    );

    // Both mappers see the same request stream, side by side
    mmio512_map u_mmio512 (
        .clk      (clk),
        .rst      (rst),
        .mmio_req (mmio_req),
        .line_wr  (line_wr)
    );

    afu_csr u_csr (
        .clk     (clk),
        .rst     (rst),
        .reg_req (reg_req),
        .reg_rsp (reg_rsp),
        .line_wr (line_wr)
    );

endmodule

`default_nettype wire

//--- source/afu_csr.sv
// Accelerator CSR bank with ID, scratch words, write count and the line store
`default_nettype none

module afu_csr import host_chan_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire reg_req_t reg_req,
    output reg_rsp_t      reg_rsp,
    input  wire line_wr_t line_wr
);

    // ====================
    // Storage
    // ====================

    logic [SCRATCH_WORDS-1:0][WORD_W-1:0] scratch;
    line_u                                line_q;
    logic [WORD_W-1:0]                    wr_count;

    // ====================
    // Address decode
    // ====================

    logic [WADDR_W-1:0] scr_off;
    logic [WADDR_W-1:0] line_off;
    logic               hit_id;
    logic               hit_scr;
    logic               hit_count;
    logic               hit_line;
    logic               scr_wr;
    logic               line_word_wr;
    logic               count_inc;
    logic [WORD_W:0]    count_sum;
    logic [WORD_W-1:0]  rd_data;

    // Offsets from each region base, an address below a base wraps to a large value
    assign scr_off  = reg_req.addr - CSR_SCRATCH_BASE[ADDR_W-1:3];
    assign line_off = reg_req.addr - LINE_BASE[ADDR_W-1:3];

    assign hit_id    = (reg_req.addr == CSR_ID_ADDR[ADDR_W-1:3]);
    assign hit_scr   = (scr_off < WADDR_W'(SCRATCH_WORDS));
    assign hit_count = (reg_req.addr == CSR_WR_COUNT_ADDR[ADDR_W-1:3]);
    assign hit_line  = (line_off < WADDR_W'(LINE_WORDS));

    // ID and count are read only, so only these two regions accept writes
    assign scr_wr       = reg_req.valid && reg_req.write && hit_scr;
    assign line_word_wr = reg_req.valid && reg_req.write && hit_line;

    // Both write sources come from the same request stage and a request is
    // either 8 or 64 bytes, so at most one accepted write arrives per cycle
    assign count_inc = line_wr.valid || scr_wr || line_word_wr;
    assign count_sum = {1'b0, wr_count} + {{WORD_W{1'b0}}, count_inc};

    // ====================
    // Register updates
    // ====================

    always_ff @(posedge clk) begin
        if (rst) begin
            scratch  <= '0;
            line_q   <= '0;
            wr_count <= '0;
        end else begin
            if (scr_wr) begin
                scratch[scr_off[$clog2(SCRATCH_WORDS)-1:0]] <= reg_req.data;
            end
            // Whole line first, a word write in the same cycle would then win
            if (line_wr.valid) begin
                line_q.line <= line_wr.data.line;
            end
            if (line_word_wr) begin
                line_q.words[line_off[$clog2(LINE_WORDS)-1:0]] <= reg_req.data;
            end
            // Saturate instead of wrapping when the carry bit sets
            if (count_sum[WORD_W]) begin
                wr_count <= '1;
            end else begin
                wr_count <= count_sum[WORD_W-1:0];
            end
        end
    end

    // ====================
    // Read path
    // ====================

    // Unmapped addresses read as zero
    always_comb begin
        rd_data = '0;
        if (hit_id) begin
            rd_data = AFU_ID;
        end else if (hit_scr) begin
            rd_data = scratch[scr_off[$clog2(SCRATCH_WORDS)-1:0]];
        end else if (hit_count) begin
            rd_data = wr_count;
        end else if (hit_line) begin
            rd_data = line_q.words[line_off[$clog2(LINE_WORDS)-1:0]];
        end
    end

    // Response is registered, one cycle after the request, and keeps its tag
    always_ff @(posedge clk) begin
        reg_rsp.data <= rd_data;
        reg_rsp.tid  <= reg_req.tid;
        if (rst) begin
            reg_rsp.valid <= 1'b0;
        end else begin
            reg_rsp.valid <= reg_req.valid && !reg_req.write;
        end
    end

endmodule

`default_nettype wire

//--- source/mmio512_map.sv
// Mapper from 64-byte MMIO writes at the line address to 512-bit line writes
`default_nettype none

module mmio512_map import host_chan_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire mmio_req_t mmio_req,
    output line_wr_t       line_wr
);

    logic line_hit;

    // This port is write only
    // A full line write must land exactly on LINE_BASE, anything else is ignored
    assign line_hit = mmio_req.valid
                   && mmio_req.write
                   && (mmio_req.len == LEN_64B)
                   && (mmio_req.addr == LINE_BASE);

    // Single register stage, same depth as the 64-bit mapper so both
    // kinds of write reach the CSR block in arrival order
    always_ff @(posedge clk) begin
        line_wr.data <= mmio_req.data;
        if (rst) begin
            line_wr.valid <= 1'b0;
        end else begin
            line_wr.valid <= line_hit;
        end
    end

endmodule

`default_nettype wire

//--- source/mmio64_map.sv
// Mapper from 8-byte MMIO requests to 64-bit register requests and responses
`default_nettype none

module mmio64_map import host_chan_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire mmio_req_t mmio_req,
    output reg_req_t       reg_req,
    input  wire reg_rsp_t  reg_rsp,
    output reg_rsp_t       mmio_rsp
);

    logic accept;

    // Only 8-byte requests belong to this mapper
    // 64-byte writes are taken by the line mapper and 64-byte reads are
    // simply dropped, so they never get a response
    assign accept = mmio_req.valid && (mmio_req.len == LEN_8B);

    // ====================
    // Request path
    // ====================

    // One register stage toward the CSR block
    // The byte address loses its three offset bits to become a word address
    // and write data is taken from the low word of the line union
    always_ff @(posedge clk) begin
        reg_req.write <= mmio_req.write;
        reg_req.addr  <= mmio_req.addr[ADDR_W-1:3];
        reg_req.data  <= mmio_req.data.words[0];
        reg_req.tid   <= mmio_req.tid;
        if (rst) begin
            reg_req.valid <= 1'b0;
        end else begin
            reg_req.valid <= accept;
        end
    end

    // ====================
    // Response path
    // ====================

    // The tag travels through the CSR block with the request, so the
    // response is forwarded as is without any added latency
    always_comb begin
        mmio_rsp.valid = reg_rsp.valid;
        mmio_rsp.data  = reg_rsp.data;
        mmio_rsp.tid   = reg_rsp.tid;
    end

endmodule

`default_nettype wire

//--- source/mmio_split.sv
// MMIO splitter with receive and transmit register stages for the host channel
`default_nettype none

module mmio_split import host_chan_pkg::*; (
    input  wire logic      clk,
    input  wire logic      rst,
    input  wire rx_word_t  rx,
    output mmio_req_t      mmio_req,
    input  wire reg_rsp_t  mmio_rsp,
    output tx_word_t       tx
);

    logic is_mmio;

    // Only the two MMIO kinds go on, host memory responses and idle words are dropped
    assign is_mmio = (rx.kind == KIND_MMIO_RD) || (rx.kind == KIND_MMIO_WR);

    // Receive side timing stage
    // Payload is captured every cycle and only the strobe is reset
    always_ff @(posedge clk) begin
        mmio_req.write <= (rx.kind == KIND_MMIO_WR);
        mmio_req.addr  <= rx.addr;
        mmio_req.len   <= rx.len;
        mmio_req.tid   <= rx.tid;
        mmio_req.data  <= rx.data;
        if (rst) begin
            mmio_req.valid <= 1'b0;
        end else begin
            mmio_req.valid <= is_mmio;
        end
    end

    // Transmit side timing stage
    // The host memory request path contributes nothing here, so tx holds
    // only the MMIO read responses coming back from the 64-bit mapper
    always_ff @(posedge clk) begin
        tx.tid  <= mmio_rsp.tid;
        tx.data <= mmio_rsp.data;
        if (rst) begin
            tx.valid <= 1'b0;
        end else begin
            tx.valid <= mmio_rsp.valid;
        end
    end

endmodule

`default_nettype wire

//--- source/host_chan_pkg.sv
// Sizes, address map, channel word structs and the line union for the host channel front
`default_nettype none

package host_chan_pkg;

    // ====================
    // Sizes
    // ====================

    localparam int ADDR_W        = 16;
    localparam int TID_W         = 9;
    localparam int LINE_W        = 512;
    localparam int WORD_W        = 64;
    localparam int LINE_WORDS    = 8;
    localparam int SCRATCH_WORDS = 4;

    // Register requests carry word addresses, so the byte offset bits are gone
    localparam int WADDR_W = ADDR_W - 3;

    // ====================
    // Address map
    // ====================

    // Fixed identification value returned at CSR_ID_ADDR
    localparam logic [WORD_W-1:0] AFU_ID = 64'h4846_5f41_4655_0001;

    localparam logic [ADDR_W-1:0] CSR_ID_ADDR       = 16'h0000;
    localparam logic [ADDR_W-1:0] CSR_SCRATCH_BASE  = 16'h0008;
    localparam logic [ADDR_W-1:0] CSR_WR_COUNT_ADDR = 16'h0028;
    // The line occupies eight words, 0x100 up to 0x13F
    localparam logic [ADDR_W-1:0] LINE_BASE         = 16'h0100;

    // ====================
    // Channel types
    // ====================

    // Kind of a receive word, KIND_NONE marks an idle cycle
    typedef enum logic [1:0] {
        KIND_NONE     = 2'd0,
        KIND_MMIO_RD  = 2'd1,
        KIND_MMIO_WR  = 2'd2,
        KIND_HOST_RSP = 2'd3
    } chan_kind_e;

    typedef enum logic [1:0] {
        LEN_8B  = 2'd0,
        LEN_64B = 2'd1
    } mmio_len_e;

    // One line seen whole by the 512-bit writer, or as words by 64-bit access
    typedef union packed {
        logic [LINE_W-1:0]                 line;
        logic [LINE_WORDS-1:0][WORD_W-1:0] words;
    } line_u;

    typedef struct packed {
        chan_kind_e        kind;
        logic [ADDR_W-1:0] addr;
        mmio_len_e         len;
        logic [TID_W-1:0]  tid;
        line_u             data;
    } rx_word_t;

    // MMIO request after the split, host responses are gone so one bit tells the direction
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [ADDR_W-1:0] addr;
        mmio_len_e         len;
        logic [TID_W-1:0]  tid;
        line_u             data;
    } mmio_req_t;

    typedef struct packed {
        logic               valid;
        logic               write;
        logic [WADDR_W-1:0] addr;
        logic [WORD_W-1:0]  data;
        logic [TID_W-1:0]   tid;
    } reg_req_t;

    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] data;
        logic [TID_W-1:0]  tid;
    } reg_rsp_t;

    typedef struct packed {
        logic  valid;
        line_u data;
    } line_wr_t;

    // Read response as it leaves on the transmit channel
    typedef struct packed {
        logic              valid;
        logic [TID_W-1:0]  tid;
        logic [WORD_W-1:0] data;
    } tx_word_t;

endpackage

`default_nettype wire
